// ==== nkmd_cpu.f ====
+incdir+include
verilog/nkmd_cpu_pkg.sv
verilog/nkmd_cpu_if.sv
verilog/nkmd_cpu_dcd.sv
verilog/nkmd_cpu_regfile.sv
verilog/nkmd_cpu_mem.sv
verilog/nkmd_cpu_ex.sv
verilog/nkmd_cpu.sv
verif/nkmd_cpu_tb_clk.sv
verif/nkmd_cpu_tb.sv

// ==== Makefile ====
VERILATOR ?= verilator
TOP       ?= nkmd_cpu_tb
FILELIST  ?= nkmd_cpu.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing --assert -j 0

SIM_BIN := $(BUILD_DIR)/V$(TOP)
SOURCES := $(wildcard verilog/*.sv verif/*.sv include/*.svh)

.PHONY: all compile run clean

all: run

compile: $(SIM_BIN)

$(SIM_BIN): $(FILELIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

run: compile
	./$(SIM_BIN)

clean:
	rm -rf $(BUILD_DIR)

// ==== verif/nkmd_cpu_tb.sv ====
`default_nettype none
`timescale 1ns/1ps

`include "nkmd_cpu_consts.svh"

module nkmd_cpu_tb;

    localparam int PROG_LEN      = 200;
    localparam int MEM_WORDS     = 256;
    localparam int MAX_STEPS     = 1000;
    localparam int RESET_TIMEOUT = 50;
    localparam int RUN_TIMEOUT   = 5000;
    localparam int DRAIN_CYCLES  = 20;
    localparam int unsigned SEED = 32'he894c3e6;

    logic                 clk;
    logic                 rst;
    logic [`CPU_XLEN-1:0] p_data_i;
    logic [`CPU_XLEN-1:0] p_addr_o;
    logic [`CPU_XLEN-1:0] r_data_i;
    logic [`CPU_XLEN-1:0] r_data_o;
    logic [`CPU_XLEN-1:0] r_addr_o;
    logic                 r_we_o;

    logic [`CPU_XLEN-1:0] rom [0:MEM_WORDS-1];
    logic [`CPU_XLEN-1:0] ram [0:MEM_WORDS-1];

    // Expected behavior from the ISA model
    logic [`CPU_XLEN-1:0] trace_pc [$];
    bit                   trace_taken [$];
    bit                   trace_store [$];
    logic [`CPU_XLEN-1:0] exp_st_addr [$];
    logic [`CPU_XLEN-1:0] exp_st_data [$];

    int                   cyc_cnt;
    int                   trace_idx;
    int                   skip_cnt;
    int                   store_cnt;
    int                   we_cycle [$];

    nkmd_cpu_tb_clk i_clk (
        .clk_o (clk),
        .rst_o (rst)
    );

    nkmd_cpu i_dut (
        .clk      (clk),
        .rst      (rst),
        .p_data_i (p_data_i),
        .p_addr_o (p_addr_o),
        .r_data_i (r_data_i),
        .r_data_o (r_data_o),
        .r_addr_o (r_addr_o),
        .r_we_o   (r_we_o)
    );

    task automatic report_failure();
        $display("** FAIL **");
        $fatal(1, "Simulation stopped at the first error");
    endtask

    function automatic bit reg_is_hardwired(logic [3:0] r);
        return (r == 4'd0) || (r == 4'(`CPU_REG_RA)) || (r == 4'(`CPU_REG_PC));
    endfunction

    function automatic logic [31:0] alu_model(logic [2:0] op, logic [31:0] a, logic [31:0] b);
        logic [31:0] res;
        case (op)
            nkmd_cpu_pkg::ALU_ADD: res = a + b;
            nkmd_cpu_pkg::ALU_SUB: res = a - b;
            nkmd_cpu_pkg::ALU_AND: res = a & b;
            nkmd_cpu_pkg::ALU_OR:  res = a | b;
            nkmd_cpu_pkg::ALU_XOR: res = a ^ b;
            nkmd_cpu_pkg::ALU_SHL: res = a << b[4:0];
            nkmd_cpu_pkg::ALU_SHR: res = a >> b[4:0];
            default:               res = b;
        endcase
        return res;
    endfunction

    function automatic logic [31:0] make_inst(logic [3:0] cls, logic [2:0] op, logic [3:0] rd,
                                              logic [3:0] rs, logic [15:0] low);
        logic [31:0] w;
        w = '0;
        w[`DCD_CLASS_LSB +: `DCD_CLASS_W]   = cls;
        w[`DCD_ALUSEL_LSB +: `DCD_ALUSEL_W] = op;
        w[`DCD_RD_LSB +: `DCD_REGSEL_W]     = rd;
        w[`DCD_RS_LSB +: `DCD_REGSEL_W]     = rs;
        w[`DCD_IMM_SIGN:0]                  = low;
        return w;
    endfunction

    task automatic build_program();
        logic [31:0] rnd;
        logic [3:0]  cls;
        int          pick;
        int          max_rel;
        for (int i = 0; i < PROG_LEN - 2; i++) begin
            rnd  = $urandom();
            pick = int'($urandom_range(99));
            if (pick < 30)
                cls = nkmd_cpu_pkg::CLS_ALU_RR;
            else if (pick < 55)
                cls = nkmd_cpu_pkg::CLS_ALU_RI;
            else if (pick < 67)
                cls = nkmd_cpu_pkg::CLS_LOAD;
            else if (pick < 85)
                cls = nkmd_cpu_pkg::CLS_STORE;
            else if (pick < 93)
                cls = nkmd_cpu_pkg::CLS_JNZ;
            else
                cls = 4'($urandom_range(15, 5));
            rnd[`DCD_CLASS_LSB +: `DCD_CLASS_W] = cls;
            // Forward only, never past the setup of the final loop
            if (cls == nkmd_cpu_pkg::CLS_JNZ) begin
                max_rel = (PROG_LEN - 2 - i < 24) ? PROG_LEN - 2 - i : 24;
                rnd[`DCD_JMPREL_LSB +: `DCD_JMPREL_W] = 8'($urandom_range(max_rel, 1));
            end
            rom[i] = rnd;
        end
        // r1 = 1, then a self-jump on r1
        rom[PROG_LEN-2] = make_inst(nkmd_cpu_pkg::CLS_ALU_RI, nkmd_cpu_pkg::ALU_PASS_B,
                                    4'd1, 4'd0, 16'd1);
        rom[PROG_LEN-1] = make_inst(nkmd_cpu_pkg::CLS_JNZ, nkmd_cpu_pkg::ALU_ADD,
                                    4'd0, 4'd1, 16'd0);
        for (int i = PROG_LEN; i < MEM_WORDS; i++) begin
            rom[i] = {4'hf, 20'h0, 8'(i)};
        end
        for (int i = 0; i < MEM_WORDS; i++) begin
            ram[i] = {8'(i), ~8'(i), 8'(i) ^ 8'ha5, 8'h3c};
        end
    endtask

    task automatic run_model();
        logic [31:0] regs [0:15];
        logic [31:0] mram [0:MEM_WORDS-1];
        logic [31:0] pc;
        logic [31:0] next_pc;
        logic [31:0] inst;
        logic [31:0] rs_val;
        logic [31:0] rt_val;
        logic [31:0] imm;
        logic [31:0] rel;
        logic [31:0] wval;
        logic [3:0]  cls;
        logic [3:0]  rd;
        logic [3:0]  rs;
        logic [3:0]  rt;
        logic [2:0]  op;
        bit          wen;
        bit          taken;
        bit          done;
        int          steps;
        for (int i = 0; i < 16; i++) begin
            regs[i] = '0;
        end
        for (int i = 0; i < MEM_WORDS; i++) begin
            mram[i] = ram[i];
        end
        pc    = `CPU_RESET_PC;
        done  = 1'b0;
        steps = 0;
        while (!done) begin
            inst   = rom[pc[7:0]];
            cls    = inst[`DCD_CLASS_LSB +: `DCD_CLASS_W];
            rd     = inst[`DCD_RD_LSB +: `DCD_REGSEL_W];
            rs     = inst[`DCD_RS_LSB +: `DCD_REGSEL_W];
            rt     = inst[`DCD_RT_LSB +: `DCD_REGSEL_W];
            op     = inst[`DCD_ALUSEL_LSB +: `DCD_ALUSEL_W];
            imm    = {{(`CPU_XLEN - `DCD_IMM_SIGN){inst[`DCD_IMM_SIGN]}},
                      inst[`DCD_IMM_SIGN-1:0]};
            rel    = {{(`CPU_XLEN - `DCD_JMPREL_W){inst[`DCD_JMPREL_W-1]}},
                      inst[`DCD_JMPREL_LSB +: `DCD_JMPREL_W]};
            rs_val = reg_is_hardwired(rs) ? '0 : regs[rs];
            rt_val = reg_is_hardwired(rt) ? '0 : regs[rt];
            next_pc = pc + `CPU_XLEN'(1);
            wen     = 1'b0;
            wval    = '0;
            taken   = 1'b0;
            case (cls)
                nkmd_cpu_pkg::CLS_ALU_RR: begin
                    wen  = 1'b1;
                    wval = alu_model(op, rs_val, rt_val);
                end
                nkmd_cpu_pkg::CLS_ALU_RI: begin
                    wen  = 1'b1;
                    wval = alu_model(op, rs_val, imm);
                end
                nkmd_cpu_pkg::CLS_LOAD: begin
                    wen  = 1'b1;
                    wval = mram[rs_val[7:0]];
                end
                nkmd_cpu_pkg::CLS_STORE: begin
                    mram[rs_val[7:0]] = rt_val;
                    exp_st_addr.push_back(rs_val);
                    exp_st_data.push_back(rt_val);
                end
                nkmd_cpu_pkg::CLS_JNZ: begin
                    if (rs_val != '0) begin
                        taken   = 1'b1;
                        next_pc = pc + rel;
                    end
                end
                default: begin
                end
            endcase
            if (wen && !reg_is_hardwired(rd))
                regs[rd] = wval;
            trace_pc.push_back(pc);
            trace_taken.push_back(taken);
            trace_store.push_back(cls == nkmd_cpu_pkg::CLS_STORE);
            if (taken && (next_pc == pc))
                done = 1'b1;
            steps++;
            if (steps > MAX_STEPS) begin
                $display("ISA model did not reach the final self-jump");
                report_failure();
            end
            pc = next_pc;
        end
    endtask

    // One cycle of checks, outputs sampled mid-cycle
    task automatic check_cycle();
        bit exp_we;
        exp_we = (we_cycle.size() > 0) && (we_cycle[0] == cyc_cnt);
        assert (r_we_o == exp_we) else begin
            $display("CHECK FAILED: r_we_o = %h, expected %h (cycle %0d)",
                     r_we_o, exp_we, cyc_cnt);
            report_failure();
        end
        if (exp_we) begin
            void'(we_cycle.pop_front());
            assert (r_addr_o == exp_st_addr[store_cnt]) else begin
                $display("CHECK FAILED: r_addr_o = %h, expected %h (store %0d)",
                         r_addr_o, exp_st_addr[store_cnt], store_cnt);
                report_failure();
            end
            assert (r_data_o == exp_st_data[store_cnt]) else begin
                $display("CHECK FAILED: r_data_o = %h, expected %h (store %0d)",
                         r_data_o, exp_st_data[store_cnt], store_cnt);
                report_failure();
            end
            store_cnt++;
        end
        if (cyc_cnt == 0) begin
            assert (p_addr_o == `CPU_RESET_PC) else begin
                $display("CHECK FAILED: p_addr_o = %h, expected %h after reset",
                         p_addr_o, `CPU_RESET_PC);
                report_failure();
            end
        end
        // Fetches behind a taken jump are discarded
        if (skip_cnt > 0) begin
            skip_cnt--;
        end else if (trace_idx < trace_pc.size()) begin
            assert (p_addr_o == trace_pc[trace_idx]) else begin
                $display("CHECK FAILED: p_addr_o = %h, expected %h (step %0d)",
                         p_addr_o, trace_pc[trace_idx], trace_idx);
                report_failure();
            end
            if (trace_store[trace_idx])
                we_cycle.push_back(cyc_cnt + 3);
            if (trace_taken[trace_idx])
                skip_cnt = 4;
            trace_idx++;
        end
        cyc_cnt++;
    endtask

    // ROM and RAM models with one cycle of read latency
    initial begin
        logic [31:0] p_addr_q;
        logic [31:0] rd_word;
        p_data_i = '0;
        r_data_i = '0;
        forever begin
            @(negedge clk);
            p_addr_q = p_addr_o;
            rd_word  = ram[r_addr_o[7:0]];
            if (rst) begin
                assert (r_we_o == 1'b0) else begin
                    $display("CHECK FAILED: r_we_o = %h, expected %h in reset", r_we_o, 1'b0);
                    report_failure();
                end
            end else begin
                check_cycle();
            end
            if (r_we_o)
                ram[r_addr_o[7:0]] = r_data_o;
            @(posedge clk);
            #1;
            p_data_i = rom[p_addr_q[7:0]];
            r_data_i = rd_word;
        end
    end

    initial begin
        int waited;
        void'($urandom(SEED));
        cyc_cnt   = 0;
        trace_idx = 0;
        skip_cnt  = 0;
        store_cnt = 0;
        build_program();
        run_model();
        $display("Program of %0d words, %0d steps, %0d stores expected",
                 PROG_LEN, trace_pc.size(), exp_st_addr.size());

        waited = 0;
        while (rst) begin
            @(posedge clk);
            waited++;
            if (waited > RESET_TIMEOUT) begin
                $display("Timeout waiting for reset to be released");
                report_failure();
            end
        end

        waited = 0;
        while ((store_cnt < exp_st_addr.size()) || (trace_idx < trace_pc.size())) begin
            @(posedge clk);
            waited++;
            if (waited > RUN_TIMEOUT) begin
                $display("Timeout with %0d of %0d stores and %0d of %0d fetches seen",
                         store_cnt, exp_st_addr.size(), trace_idx, trace_pc.size());
                report_failure();
            end
        end

        // An extra store in this window fails the r_we_o check
        repeat (DRAIN_CYCLES) @(posedge clk);
        $display("** PASS **");
        $finish;
    end

endmodule

`default_nettype wire

// ==== verif/nkmd_cpu_tb_clk.sv ====
`default_nettype none
`timescale 1ns/1ps

module nkmd_cpu_tb_clk #(
    parameter int HALF_PERIOD_NS = 4,
    parameter int RESET_CYCLES   = 3
) (
    output logic clk_o,
    output logic rst_o
);

    initial begin
        clk_o = 1'b0;
        forever begin
            #HALF_PERIOD_NS;
            clk_o = ~clk_o;
        end
    end

    // Released just after an edge, like the other inputs
    initial begin
        rst_o = 1'b1;
        repeat (RESET_CYCLES) @(posedge clk_o);
        #1;
        rst_o = 1'b0;
    end

endmodule

`default_nettype wire

// ==== verilog/nkmd_cpu.sv ====
`default_nettype none
`timescale 1ns/1ps

`include "nkmd_cpu_consts.svh"

module nkmd_cpu (
    input  wire logic                 clk,
    input  wire logic                 rst,

    // Bus P: program ROM
    input  wire logic [`CPU_XLEN-1:0] p_data_i,
    output logic      [`CPU_XLEN-1:0] p_addr_o,

    // Bus R: RAM and memory-mapped I/O
    input  wire logic [`CPU_XLEN-1:0] r_data_i,
    output logic      [`CPU_XLEN-1:0] r_data_o,
    output logic      [`CPU_XLEN-1:0] r_addr_o,
    output logic                      r_we_o
);

    // Fetch to decode
    logic [`CPU_XLEN-1:0]      if_inst;
    logic [`CPU_XLEN-1:0]      if_pc;
    logic                      if_valid;

    // Decode to regfile and memory stage
    nkmd_cpu_pkg::regsel_t     dcd_rssel;
    nkmd_cpu_pkg::regsel_t     dcd_rtsel;
    nkmd_cpu_pkg::regsel_t     dcd_rdsel;
    nkmd_cpu_pkg::inst_class_e dcd_class;
    nkmd_cpu_pkg::alu_op_e     dcd_alusel;
    logic [`CPU_XLEN-1:0]      dcd_imm;
    logic [`CPU_XLEN-1:0]      dcd_jmprel;
    logic [`CPU_XLEN-1:0]      dcd_pc;
    logic                      dcd_valid;

    // Regfile to memory stage
    logic [`CPU_XLEN-1:0]      rf_rsval;
    logic [`CPU_XLEN-1:0]      rf_rtval;

    // Memory stage to execute
    logic [`CPU_XLEN-1:0]      mem_rsval;
    logic [`CPU_XLEN-1:0]      mem_rtval;
    nkmd_cpu_pkg::regsel_t     mem_rdsel;
    nkmd_cpu_pkg::inst_class_e mem_class;
    nkmd_cpu_pkg::alu_op_e     mem_alusel;
    logic [`CPU_XLEN-1:0]      mem_imm;
    logic [`CPU_XLEN-1:0]      mem_jmprel;
    logic [`CPU_XLEN-1:0]      mem_pc;
    logic                      mem_valid;

    // Execute results, write back and redirect
    logic                      ex_we;
    nkmd_cpu_pkg::regsel_t     ex_wsel;
    logic [`CPU_XLEN-1:0]      ex_wdata;
    logic                      ex_redirect;
    logic [`CPU_XLEN-1:0]      ex_redirect_pc;

    nkmd_cpu_if i_if (
        .clk           (clk),
        .rst           (rst),
        .p_data_i      (p_data_i),
        .p_addr_o      (p_addr_o),
        .redirect_i    (ex_redirect),
        .redirect_pc_i (ex_redirect_pc),
        .inst_o        (if_inst),
        .pc_o          (if_pc),
        .valid_o       (if_valid)
    );

    nkmd_cpu_dcd i_dcd (
        .clk      (clk),
        .rst      (rst),
        .inst_i   (if_inst),
        .pc_i     (if_pc),
        .valid_i  (if_valid),
        .flush_i  (ex_redirect),
        .rssel_o  (dcd_rssel),
        .rtsel_o  (dcd_rtsel),
        .rdsel_o  (dcd_rdsel),
        .class_o  (dcd_class),
        .alusel_o (dcd_alusel),
        .imm_o    (dcd_imm),
        .jmprel_o (dcd_jmprel),
        .pc_o     (dcd_pc),
        .valid_o  (dcd_valid)
    );

    nkmd_cpu_regfile i_regfile (
        .clk     (clk),
        .rst     (rst),
        .rssel_i (dcd_rssel),
        .rtsel_i (dcd_rtsel),
        .rsval_o (rf_rsval),
        .rtval_o (rf_rtval),
        .we_i    (ex_we),
        .wsel_i  (ex_wsel),
        .wdata_i (ex_wdata)
    );

    nkmd_cpu_mem i_mem (
        .clk        (clk),
        .rst        (rst),
        .rssel_i    (dcd_rssel),
        .rtsel_i    (dcd_rtsel),
        .rdsel_i    (dcd_rdsel),
        .class_i    (dcd_class),
        .alusel_i   (dcd_alusel),
        .imm_i      (dcd_imm),
        .jmprel_i   (dcd_jmprel),
        .pc_i       (dcd_pc),
        .valid_i    (dcd_valid),
        .rsval_i    (rf_rsval),
        .rtval_i    (rf_rtval),
        .fwd_we_i   (ex_we),
        .fwd_sel_i  (ex_wsel),
        .fwd_data_i (ex_wdata),
        .flush_i    (ex_redirect),
        .r_addr_o   (r_addr_o),
        .r_data_o   (r_data_o),
        .r_we_o     (r_we_o),
        .rsval_o    (mem_rsval),
        .rtval_o    (mem_rtval),
        .rdsel_o    (mem_rdsel),
        .class_o    (mem_class),
        .alusel_o   (mem_alusel),
        .imm_o      (mem_imm),
        .jmprel_o   (mem_jmprel),
        .pc_o       (mem_pc),
        .valid_o    (mem_valid)
    );

    nkmd_cpu_ex i_ex (
        .rsval_i       (mem_rsval),
        .rtval_i       (mem_rtval),
        .rdsel_i       (mem_rdsel),
        .class_i       (mem_class),
        .alusel_i      (mem_alusel),
        .imm_i         (mem_imm),
        .jmprel_i      (mem_jmprel),
        .pc_i          (mem_pc),
        .valid_i       (mem_valid),
        .r_data_i      (r_data_i),
        .rf_we_o       (ex_we),
        .rf_wsel_o     (ex_wsel),
        .rf_wdata_o    (ex_wdata),
        .redirect_o    (ex_redirect),
        .redirect_pc_o (ex_redirect_pc)
    );

endmodule

`default_nettype wire

// ==== verilog/nkmd_cpu_ex.sv ====
`default_nettype none
`timescale 1ns/1ps

`include "nkmd_cpu_consts.svh"

module nkmd_cpu_ex (
    input  wire logic        [`CPU_XLEN-1:0] rsval_i,
    input  wire logic        [`CPU_XLEN-1:0] rtval_i,
    input  wire nkmd_cpu_pkg::regsel_t       rdsel_i,
    input  wire nkmd_cpu_pkg::inst_class_e   class_i,
    input  wire nkmd_cpu_pkg::alu_op_e       alusel_i,
    input  wire logic        [`CPU_XLEN-1:0] imm_i,
    input  wire logic        [`CPU_XLEN-1:0] jmprel_i,
    input  wire logic        [`CPU_XLEN-1:0] pc_i,
    input  wire logic                        valid_i,

    // Bus R read data for a load issued last cycle
    input  wire logic        [`CPU_XLEN-1:0] r_data_i,

    // Write back
    output logic                             rf_we_o,
    output nkmd_cpu_pkg::regsel_t            rf_wsel_o,
    output logic             [`CPU_XLEN-1:0] rf_wdata_o,

    // Taken jump, also flushes the younger stages
    output logic                             redirect_o,
    output logic             [`CPU_XLEN-1:0] redirect_pc_o
);

    localparam int unsigned SHAMT_W = $clog2(`CPU_XLEN);

    logic [`CPU_XLEN-1:0] opb;
    logic [`CPU_XLEN-1:0] alu_res;

    always_comb begin
        opb = (class_i == nkmd_cpu_pkg::CLS_ALU_RI) ? imm_i : rtval_i;
        case (alusel_i)
            nkmd_cpu_pkg::ALU_ADD:    alu_res = rsval_i + opb;
            nkmd_cpu_pkg::ALU_SUB:    alu_res = rsval_i - opb;
            nkmd_cpu_pkg::ALU_AND:    alu_res = rsval_i & opb;
            nkmd_cpu_pkg::ALU_OR:     alu_res = rsval_i | opb;
            nkmd_cpu_pkg::ALU_XOR:    alu_res = rsval_i ^ opb;
            nkmd_cpu_pkg::ALU_SHL:    alu_res = rsval_i << opb[SHAMT_W-1:0];
            nkmd_cpu_pkg::ALU_SHR:    alu_res = rsval_i >> opb[SHAMT_W-1:0];
            nkmd_cpu_pkg::ALU_PASS_B: alu_res = opb;
            default:                  alu_res = opb;
        endcase
    end

    // rd is already zero for classes with no write back
    assign rf_we_o    = valid_i && (rdsel_i != '0);
    assign rf_wsel_o  = rdsel_i;
    assign rf_wdata_o = (class_i == nkmd_cpu_pkg::CLS_LOAD) ? r_data_i : alu_res;

    assign redirect_o    = valid_i && (class_i == nkmd_cpu_pkg::CLS_JNZ) && (rsval_i != '0);
    // Relative to the jump's own address
    assign redirect_pc_o = pc_i + jmprel_i;

endmodule

`default_nettype wire

// ==== verilog/nkmd_cpu_mem.sv ====
`default_nettype none
`timescale 1ns/1ps

`include "nkmd_cpu_consts.svh"

module nkmd_cpu_mem (
    input  wire logic                        clk,
    input  wire logic                        rst,

    // From decode, one cycle ahead of the regfile values
    input  wire nkmd_cpu_pkg::regsel_t       rssel_i,
    input  wire nkmd_cpu_pkg::regsel_t       rtsel_i,
    input  wire nkmd_cpu_pkg::regsel_t       rdsel_i,
    input  wire nkmd_cpu_pkg::inst_class_e   class_i,
    input  wire nkmd_cpu_pkg::alu_op_e       alusel_i,
    input  wire logic        [`CPU_XLEN-1:0] imm_i,
    input  wire logic        [`CPU_XLEN-1:0] jmprel_i,
    input  wire logic        [`CPU_XLEN-1:0] pc_i,
    input  wire logic                        valid_i,

    input  wire logic        [`CPU_XLEN-1:0] rsval_i,
    input  wire logic        [`CPU_XLEN-1:0] rtval_i,

    // Result retiring in execute this cycle
    input  wire logic                        fwd_we_i,
    input  wire nkmd_cpu_pkg::regsel_t       fwd_sel_i,
    input  wire logic        [`CPU_XLEN-1:0] fwd_data_i,
    input  wire logic                        flush_i,

    // Bus R
    output logic             [`CPU_XLEN-1:0] r_addr_o,
    output logic             [`CPU_XLEN-1:0] r_data_o,
    output logic                             r_we_o,

    // To execute
    output logic             [`CPU_XLEN-1:0] rsval_o,
    output logic             [`CPU_XLEN-1:0] rtval_o,
    output nkmd_cpu_pkg::regsel_t            rdsel_o,
    output nkmd_cpu_pkg::inst_class_e        class_o,
    output nkmd_cpu_pkg::alu_op_e            alusel_o,
    output logic             [`CPU_XLEN-1:0] imm_o,
    output logic             [`CPU_XLEN-1:0] jmprel_o,
    output logic             [`CPU_XLEN-1:0] pc_o,
    output logic                             valid_o
);

    // Register-read stage, waits for the regfile values
    nkmd_cpu_pkg::regsel_t     rr_rssel_ff;
    nkmd_cpu_pkg::regsel_t     rr_rtsel_ff;
    nkmd_cpu_pkg::regsel_t     rr_rdsel_ff;
    nkmd_cpu_pkg::inst_class_e rr_class_ff;
    nkmd_cpu_pkg::alu_op_e     rr_alusel_ff;
    logic [`CPU_XLEN-1:0]      rr_imm_ff;
    logic [`CPU_XLEN-1:0]      rr_jmprel_ff;
    logic [`CPU_XLEN-1:0]      rr_pc_ff;
    logic                      rr_valid_ff;

    logic [`CPU_XLEN-1:0]      rs_fwd;
    logic [`CPU_XLEN-1:0]      rt_fwd;

    always_ff @(posedge clk) begin
        rr_rssel_ff  <= rssel_i;
        rr_rtsel_ff  <= rtsel_i;
        rr_rdsel_ff  <= rdsel_i;
        rr_class_ff  <= class_i;
        rr_alusel_ff <= alusel_i;
        rr_imm_ff    <= imm_i;
        rr_jmprel_ff <= jmprel_i;
        rr_pc_ff     <= pc_i;
    end

    // Only the immediately older instruction can still be in flight
    assign rs_fwd = (fwd_we_i && (fwd_sel_i == rr_rssel_ff) && (rr_rssel_ff != '0)) ?
                    fwd_data_i : rsval_i;
    assign rt_fwd = (fwd_we_i && (fwd_sel_i == rr_rtsel_ff) && (rr_rtsel_ff != '0)) ?
                    fwd_data_i : rtval_i;

    assign r_addr_o = rs_fwd;
    assign r_data_o = rt_fwd;
    assign r_we_o   = rr_valid_ff && (rr_class_ff == nkmd_cpu_pkg::CLS_STORE) && !flush_i;

    always_ff @(posedge clk) begin
        if (rst) begin
            rr_valid_ff <= 1'b0;
            valid_o     <= 1'b0;
        end else begin
            rr_valid_ff <= valid_i && !flush_i;
            valid_o     <= rr_valid_ff && !flush_i;
        end
    end

    always_ff @(posedge clk) begin
        rsval_o  <= rs_fwd;
        rtval_o  <= rt_fwd;
        rdsel_o  <= rr_rdsel_ff;
        class_o  <= rr_class_ff;
        alusel_o <= rr_alusel_ff;
        imm_o    <= rr_imm_ff;
        jmprel_o <= rr_jmprel_ff;
        pc_o     <= rr_pc_ff;
    end

endmodule

`default_nettype wire

// ==== verilog/nkmd_cpu_regfile.sv ====
`default_nettype none
`timescale 1ns/1ps

`include "nkmd_cpu_consts.svh"

module nkmd_cpu_regfile (
    input  wire logic                  clk,
    input  wire logic                  rst,

    // Read ports, one cycle latency
    input  wire nkmd_cpu_pkg::regsel_t rssel_i,
    input  wire nkmd_cpu_pkg::regsel_t rtsel_i,
    output logic       [`CPU_XLEN-1:0] rsval_o,
    output logic       [`CPU_XLEN-1:0] rtval_o,

    // Write port from execute
    input  wire logic                  we_i,
    input  wire nkmd_cpu_pkg::regsel_t wsel_i,
    input  wire logic  [`CPU_XLEN-1:0] wdata_i
);

    localparam int unsigned GPR_LAST = `CPU_REG_PC - 1;

    // Entry for ra is never written and never read
    logic [`CPU_XLEN-1:0] gpr_ff [1:GPR_LAST];

    function automatic logic [`CPU_XLEN-1:0] read_port(nkmd_cpu_pkg::regsel_t sel);
        logic [`CPU_XLEN-1:0] val;
        if (!nkmd_cpu_pkg::reg_writable(sel)) begin
            val = '0;
        end else if (we_i && (wsel_i == sel)) begin
            // Write-through of the value retiring this cycle
            val = wdata_i;
        end else begin
            val = gpr_ff[sel];
        end
        return val;
    endfunction

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 1; i <= GPR_LAST; i++) begin
                gpr_ff[i] <= '0;
            end
        end else if (we_i && nkmd_cpu_pkg::reg_writable(wsel_i)) begin
            gpr_ff[wsel_i] <= wdata_i;
        end
    end

    always_ff @(posedge clk) begin
        rsval_o <= read_port(rssel_i);
        rtval_o <= read_port(rtsel_i);
    end

endmodule

`default_nettype wire

// ==== verilog/nkmd_cpu_dcd.sv ====
`default_nettype none
`timescale 1ns/1ps

`include "nkmd_cpu_consts.svh"

module nkmd_cpu_dcd (
    input  wire logic                 clk,
    input  wire logic                 rst,

    input  wire logic [`CPU_XLEN-1:0] inst_i,
    input  wire logic [`CPU_XLEN-1:0] pc_i,
    input  wire logic                 valid_i,
    input  wire logic                 flush_i,

    output nkmd_cpu_pkg::regsel_t     rssel_o,
    output nkmd_cpu_pkg::regsel_t     rtsel_o,
    output nkmd_cpu_pkg::regsel_t     rdsel_o,
    output nkmd_cpu_pkg::inst_class_e class_o,
    output nkmd_cpu_pkg::alu_op_e     alusel_o,
    output logic      [`CPU_XLEN-1:0] imm_o,
    output logic      [`CPU_XLEN-1:0] jmprel_o,
    output logic      [`CPU_XLEN-1:0] pc_o,
    output logic                      valid_o
);

    nkmd_cpu_pkg::inst_class_e cls;
    nkmd_cpu_pkg::regsel_t     rd;
    logic                      reads_rt;
    logic                      writes_rd;

    always_comb begin
        cls = nkmd_cpu_pkg::inst_class_e'(inst_i[`DCD_CLASS_LSB +: `DCD_CLASS_W]);
        rd  = inst_i[`DCD_RD_LSB +: `DCD_REGSEL_W];
        reads_rt  = (cls == nkmd_cpu_pkg::CLS_ALU_RR) || (cls == nkmd_cpu_pkg::CLS_STORE);
        writes_rd = (cls == nkmd_cpu_pkg::CLS_ALU_RR) ||
                    (cls == nkmd_cpu_pkg::CLS_ALU_RI) ||
                    (cls == nkmd_cpu_pkg::CLS_LOAD);
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            valid_o <= 1'b0;
        end else begin
            valid_o <= valid_i && !flush_i;
        end
    end

    always_ff @(posedge clk) begin
        rssel_o  <= inst_i[`DCD_RS_LSB +: `DCD_REGSEL_W];
        rtsel_o  <= reads_rt ? inst_i[`DCD_RT_LSB +: `DCD_REGSEL_W] : '0;
        // rd of zero means no write back, also for ra and pc targets
        rdsel_o  <= (writes_rd && nkmd_cpu_pkg::reg_writable(rd)) ? rd : '0;
        class_o  <= cls;
        alusel_o <= nkmd_cpu_pkg::alu_op_e'(inst_i[`DCD_ALUSEL_LSB +: `DCD_ALUSEL_W]);
        imm_o    <= {{(`CPU_XLEN - `DCD_IMM_SIGN){inst_i[`DCD_IMM_SIGN]}},
                     inst_i[`DCD_IMM_SIGN-1:0]};
        jmprel_o <= {{(`CPU_XLEN - `DCD_JMPREL_W){inst_i[`DCD_JMPREL_LSB + `DCD_JMPREL_W - 1]}},
                     inst_i[`DCD_JMPREL_LSB +: `DCD_JMPREL_W]};
        pc_o     <= pc_i;
    end

endmodule

`default_nettype wire

// ==== verilog/nkmd_cpu_if.sv ====
`default_nettype none
`timescale 1ns/1ps

`include "nkmd_cpu_consts.svh"

module nkmd_cpu_if (
    input  wire logic                 clk,
    input  wire logic                 rst,

    // Bus P
    input  wire logic [`CPU_XLEN-1:0] p_data_i,
    output logic      [`CPU_XLEN-1:0] p_addr_o,

    input  wire logic                 redirect_i,
    input  wire logic [`CPU_XLEN-1:0] redirect_pc_i,

    output logic      [`CPU_XLEN-1:0] inst_o,
    output logic      [`CPU_XLEN-1:0] pc_o,
    output logic                      valid_o
);

    logic [`CPU_XLEN-1:0] pc_ff;
    logic [`CPU_XLEN-1:0] fetch_pc_ff;
    logic                 valid_ff;

    // Word addressed, one instruction per cycle
    always_ff @(posedge clk) begin
        if (rst) begin
            pc_ff    <= `CPU_RESET_PC;
            valid_ff <= 1'b0;
        end else begin
            pc_ff    <= redirect_i ? redirect_pc_i : pc_ff + `CPU_XLEN'(1);
            // Word issued during a redirect comes back stale
            valid_ff <= !redirect_i;
        end
    end

    // Address of the fetch now in flight on bus P
    always_ff @(posedge clk) begin
        fetch_pc_ff <= pc_ff;
    end

    assign p_addr_o = pc_ff;
    assign inst_o   = p_data_i;
    assign pc_o     = fetch_pc_ff;
    assign valid_o  = valid_ff;

endmodule

`default_nettype wire

// ==== verilog/nkmd_cpu_pkg.sv ====
`default_nettype none

`include "nkmd_cpu_consts.svh"

package nkmd_cpu_pkg;

    typedef logic [`DCD_REGSEL_W-1:0] regsel_t;

    // Any class value not listed here executes as a nop
    typedef enum logic [`DCD_CLASS_W-1:0] {
        CLS_ALU_RR = 4'd0,
        CLS_ALU_RI = 4'd1,
        CLS_LOAD   = 4'd2,
        CLS_STORE  = 4'd3,
        CLS_JNZ    = 4'd4
    } inst_class_e;

    typedef enum logic [`DCD_ALUSEL_W-1:0] {
        ALU_ADD    = 3'd0,
        ALU_SUB    = 3'd1,
        ALU_AND    = 3'd2,
        ALU_OR     = 3'd3,
        ALU_XOR    = 3'd4,
        ALU_SHL    = 3'd5,
        ALU_SHR    = 3'd6,
        ALU_PASS_B = 3'd7
    } alu_op_e;

    // Zero, ra and pc are hardwired to zero
    function automatic logic reg_writable(regsel_t sel);
        return (sel != regsel_t'(0)) &&
               (sel != regsel_t'(`CPU_REG_RA)) &&
               (sel != regsel_t'(`CPU_REG_PC));
    endfunction

endpackage

`default_nettype wire

// ==== include/nkmd_cpu_consts.svh ====
`ifndef NKMD_CPU_CONSTS_SVH
`define NKMD_CPU_CONSTS_SVH

// Datapath
`define CPU_XLEN 32
`define CPU_RESET_PC 32'h0000_0000

// Read-only register numbers, always read as zero
`define CPU_REG_RA 11
`define CPU_REG_PC 15

// Field widths
`define DCD_REGSEL_W 4
`define DCD_ALUSEL_W 3
`define DCD_CLASS_W 4
`define DCD_JMPREL_W 8

// Field positions in the instruction word
`define DCD_RS_LSB 17
`define DCD_RT_LSB 8
`define DCD_RD_LSB 24
`define DCD_ALUSEL_LSB 21
`define DCD_CLASS_LSB 28
`define DCD_IMM_SIGN 15
`define DCD_JMPREL_LSB 0

`endif
